// File: memtest.f
hw/mem_cfg_pkg.sv
hw/memtest_pkg.sv
hw/sdr_ctrl_model.sv
hw/pattern_gen.sv
hw/read_checker.sv
hw/memtest_top.sv
tests/memtest_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the memory tester testbench with Verilator, run it, and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module memtest_tb -f memtest.f -o memtest_sim

sim_out=$(./obj_dir/memtest_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^Everything OK$"

// File: tests/memtest_input.txt
// columns: verify_only base_addr word_count data_seed expected_err_count busy_start
// all values hex, one test run per line, busy_start 1 pulses start again mid-run
// write a short window, then a long one across refreshes
0 0000 0010 1000 0 0
0 0100 012C A000 0 1
1 0100 012C A000 0 0
// other seed, every word differs
1 0100 0020 B000 20 0
// overwrite part of the long window, then verify across the seam
0 0200 0040 3000 0 0
1 01F0 0030 A0F0 20 0
// window crossing the array end
0 03F0 0020 5555 0 0
1 03F0 0020 5555 0 0
1 07F0 0020 5555 0 0
// first window was overwritten by the wrapped write
1 0000 0010 1000 10 0
// seed that happens to match the stored pattern
1 0008 0008 556D 0 0
// full array write with data wrapping at 16 bits
0 0000 0400 FFF0 0 1
1 0200 0100 01F0 0 0
// empty window
0 0000 0000 1234 0 0
// wrapped verify, only the part before the array end matches
1 0380 0100 0370 80 0

// File: tests/memtest_tb.sv
module memtest_tb import mem_cfg_pkg::*;
();

	localparam int INIT_CYCLES = 64;
	localparam int MAX_RUNS    = 32;
	localparam int FIELDS      = 6;		// values per line of the input file.
	localparam int WAIT_LIMIT  = 20000;

	logic   Clk;
	logic   rst_n;
	logic   start;
	logic   verify_only;
	addr_t  base_addr;
	count_t word_count;
	data_t  data_seed;
	logic   init_done;
	logic   busy;
	logic   done;
	count_t err_count;

	logic [31:0] vec [MAX_RUNS*FIELDS];
	int          checks;
	int          errors;
	int          timeouts;
	bit          aborted;

	memtest_top #(
		.INIT_CYCLES (INIT_CYCLES)
	) memtest_top_inst (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.start       (start),
		.verify_only (verify_only),
		.base_addr   (base_addr),
		.word_count  (word_count),
		.data_seed   (data_seed),
		.init_done   (init_done),
		.busy        (busy),
		.done        (done),
		.err_count   (err_count)
	);

	always #4 Clk = ~Clk;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		aborted = 1'b1;
		$display("timeout at %0t: %s", $time, what);
	endtask

	// counts rising edges from reset release until init_done is seen.
	task automatic measure_init();
		int n;
		bit seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT)
		begin
			@(posedge Clk);
			n++;
			@(negedge Clk);
			seen = init_done;
		end
		if (!seen)
			report_timeout("init_done never went high after reset");
		else
			check_value("init_latency", INIT_CYCLES, n);
	endtask

	task automatic run_test(input int row);
		logic [31:0] vonly;
		logic [31:0] base;
		logic [31:0] cnt;
		logic [31:0] seed;
		logic [31:0] exp_err;
		logic [31:0] restart;
		int          n;
		bit          finished;
		vonly   = vec[row*FIELDS];
		base    = vec[row*FIELDS+1];
		cnt     = vec[row*FIELDS+2];
		seed    = vec[row*FIELDS+3];
		exp_err = vec[row*FIELDS+4];
		restart = vec[row*FIELDS+5];
		@(posedge Clk);
		start       <= 1'b1;
		verify_only <= vonly[0];
		base_addr   <= addr_t'(base);
		word_count  <= count_t'(cnt);
		data_seed   <= data_t'(seed);
		@(posedge Clk);
		start <= 1'b0;
		@(negedge Clk);
		check_value($sformatf("busy[%0d]", row), 32'd1, 32'(busy));
		if (restart[0])
		begin
			// a second start with other settings, the seed is held for the checker.
			@(posedge Clk);
			check_value($sformatf("busy_at_restart[%0d]", row), 32'd1, 32'(busy));
			start       <= 1'b1;
			verify_only <= ~vonly[0];
			base_addr   <= addr_t'(base + 32'h40);
			word_count  <= count_t'(32'd5);
			@(posedge Clk);
			start <= 1'b0;
		end
		n        = 0;
		finished = 1'b0;
		while (!finished && n < WAIT_LIMIT)
		begin
			@(negedge Clk);
			n++;
			finished = done;
		end
		if (!finished)
			report_timeout($sformatf("run %0d never signalled done", row));
		else
		begin
			check_value($sformatf("err_count[%0d]", row), exp_err, 32'(err_count));
			check_value($sformatf("busy_at_done[%0d]", row), 32'd0, 32'(busy));
			@(negedge Clk);
			check_value($sformatf("done_pulse[%0d]", row), 32'd0, 32'(done));	// one cycle only.
			check_value($sformatf("err_hold[%0d]", row), exp_err, 32'(err_count));
		end
	endtask

	initial
	begin
		int row;
		Clk         = 1'b0;
		rst_n       = 1'b0;
		start       = 1'b0;
		verify_only = 1'b0;
		base_addr   = '0;
		word_count  = '0;
		data_seed   = '0;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		aborted     = 1'b0;
		for (int i = 0; i < MAX_RUNS*FIELDS; i++)
			vec[i] = '1;		// all ones marks the end of the runs.
		$readmemh("tests/memtest_input.txt", vec);

		repeat (2) @(posedge Clk);
		@(negedge Clk);
		check_value("init_done", 32'd0, 32'(init_done));
		check_value("busy", 32'd0, 32'(busy));
		check_value("done", 32'd0, 32'(done));
		@(posedge Clk);
		rst_n <= 1'b1;		// released after three clock edges in reset.
		measure_init();

		row = 0;
		while (!aborted && row < MAX_RUNS && vec[row*FIELDS] != '1)
		begin
			run_test(row);
			row++;
		end
		if (row == 0)
		begin
			errors++;
			$display("no test runs were read from the input file");
		end

		$display("runs %0d, checks %0d, errors %0d, timeouts %0d", row, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: hw/memtest_top.sv
module memtest_top import mem_cfg_pkg::*;
#(
	parameter int CMD_DEPTH      = 4,
	parameter int INIT_CYCLES    = 64,
	parameter int REFRESH_PERIOD = 200,
	parameter int REFRESH_CYCLES = 8,
	parameter int MEM_WORDS      = 1024
)
(
	input  logic   Clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   verify_only,
	input  addr_t  base_addr,
	input  count_t word_count,
	input  data_t  data_seed,
	output logic   init_done,
	output logic   busy,
	output logic   done,
	output count_t err_count
);

	logic   cmd_valid;
	logic   cmd_write;
	addr_t  cmd_addr;
	data_t  cmd_wdata;
	logic   cmd_credit;
	logic   rd_valid;
	data_t  rd_data;
	logic   pass_start;
	count_t reads_done;

	pattern_gen #(
		.CMD_DEPTH (CMD_DEPTH),
		.MEM_WORDS (MEM_WORDS)
	) pattern_gen_inst (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.start       (start),
		.verify_only (verify_only),
		.base_addr   (base_addr),
		.word_count  (word_count),
		.data_seed   (data_seed),
		.init_done   (init_done),
		.cmd_credit  (cmd_credit),
		.reads_done  (reads_done),
		.cmd_valid   (cmd_valid),
		.cmd_write   (cmd_write),
		.cmd_addr    (cmd_addr),
		.cmd_wdata   (cmd_wdata),
		.pass_start  (pass_start),
		.busy        (busy),
		.done        (done)
	);

	read_checker read_checker_inst (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.pass_start (pass_start),
		.data_seed  (data_seed),		// expected pattern restarts from the seed input.
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.reads_done (reads_done),
		.err_count  (err_count)
	);

	sdr_ctrl_model #(
		.CMD_DEPTH      (CMD_DEPTH),
		.INIT_CYCLES    (INIT_CYCLES),
		.REFRESH_PERIOD (REFRESH_PERIOD),
		.REFRESH_CYCLES (REFRESH_CYCLES),
		.MEM_WORDS      (MEM_WORDS)
	) sdr_ctrl_model_inst (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd_write  (cmd_write),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.cmd_credit (cmd_credit),
		.init_done  (init_done),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

endmodule

// File: hw/read_checker.sv
module read_checker import mem_cfg_pkg::*;
(
	input  logic   Clk,
	input  logic   rst_n,
	input  logic   pass_start,
	input  data_t  data_seed,
	input  logic   rd_valid,
	input  data_t  rd_data,
	output count_t reads_done,
	output count_t err_count
);

	data_t exp_data;		// next expected word.
	logic  chk_vld;
	data_t chk_data;
	data_t chk_exp;

	always_ff @(posedge Clk)
	begin
		if (pass_start)
			exp_data <= data_seed;
		else if (rd_valid)
			exp_data <= exp_data + 1'b1;
		chk_data <= rd_data;		// compare one cycle later.
		chk_exp  <= exp_data;
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			chk_vld <= 1'b0;
		else
			chk_vld <= rd_valid;
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			reads_done <= '0;
			err_count  <= '0;
		end
		else if (pass_start)
		begin
			reads_done <= '0;
			err_count  <= '0;
		end
		else if (chk_vld)
		begin
			reads_done <= reads_done + 1'b1;
			if (chk_data != chk_exp)
				err_count <= err_count + 1'b1;
		end
	end

	// more words back than any window can hold means a stray read.
	a_no_wrap: assert property (@(posedge Clk) disable iff (!rst_n)
		chk_vld |-> reads_done != '1)
		else $error("read count wrapped");

endmodule

// File: hw/pattern_gen.sv
module pattern_gen import mem_cfg_pkg::*, memtest_pkg::*;
#(
	parameter int CMD_DEPTH = 4,
	parameter int MEM_WORDS = 1024
)
(
	input  logic   Clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   verify_only,
	input  addr_t  base_addr,
	input  count_t word_count,
	input  data_t  data_seed,
	input  logic   init_done,
	input  logic   cmd_credit,
	input  count_t reads_done,
	output logic   cmd_valid,
	output logic   cmd_write,
	output addr_t  cmd_addr,
	output data_t  cmd_wdata,
	output logic   pass_start,
	output logic   busy,
	output logic   done
);

	localparam int CRED_W = $clog2(CMD_DEPTH + 1);

	gen_state_e        state;
	logic [CRED_W-1:0] credits;
	count_t            idx;			// word index within the window.
	logic              pass_end;

	addr_t             base_r;
	count_t            count_r;
	data_t             seed_r;
	logic              vonly_r;

	assign busy      = (state != IDLE);
	assign pass_end  = (idx == count_r);
	assign cmd_valid = ((state == WRITE) || (state == READ)) && !pass_end && (credits != '0);
	assign cmd_write = (state == WRITE);
	assign cmd_addr  = addr_t'((32'(base_r) + 32'(idx)) % MEM_WORDS);
	assign cmd_wdata = seed_r + data_t'(idx);		// incrementing pattern.

	// window settings are taken once per run.
	always_ff @(posedge Clk)
	begin
		if ((state == IDLE) && start)
		begin
			base_r  <= base_addr;
			count_r <= word_count;
			seed_r  <= data_seed;
			vonly_r <= verify_only;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			credits <= CRED_W'(CMD_DEPTH);
		else if (cmd_valid && !cmd_credit)
			credits <= credits - 1'b1;
		else if (!cmd_valid && cmd_credit)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state      <= IDLE;
			idx        <= '0;
			pass_start <= 1'b0;
			done       <= 1'b0;
		end
		else
		begin
			pass_start <= 1'b0;
			done       <= 1'b0;
			if (cmd_valid)
				idx <= idx + 1'b1;
			case (state)
				IDLE:
				begin
					if (start)
						state <= WAIT_INIT;
				end
				WAIT_INIT:
				begin
					idx <= '0;
					if (init_done)
					begin
						state      <= vonly_r ? READ : WRITE;
						pass_start <= vonly_r;		// verify-only goes straight to reading.
					end
				end
				WRITE:
				begin
					if (pass_end)
					begin
						state      <= READ;
						idx        <= '0;
						pass_start <= 1'b1;
					end
				end
				READ:
				begin
					if (pass_end)
						state <= DRAIN;
				end
				default:
				begin
					if (reads_done == count_r)		// every read has been checked.
					begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

	// the controller must not return more credits than were spent.
	a_credit_max: assert property (@(posedge Clk) disable iff (!rst_n)
		credits <= CRED_W'(CMD_DEPTH))
		else $error("credit count above queue depth");

endmodule

// File: hw/sdr_ctrl_model.sv
module sdr_ctrl_model import mem_cfg_pkg::*, memtest_pkg::*;
#(
	parameter int CMD_DEPTH      = 4,
	parameter int INIT_CYCLES    = 64,
	parameter int REFRESH_PERIOD = 200,
	parameter int REFRESH_CYCLES = 8,
	parameter int MEM_WORDS      = 1024
)
(
	input  logic  Clk,
	input  logic  rst_n,
	input  logic  cmd_valid,
	input  logic  cmd_write,
	input  addr_t cmd_addr,
	input  data_t cmd_wdata,
	output logic  cmd_credit,
	output logic  init_done,
	output logic  rd_valid,
	output data_t rd_data
);

	localparam int READ_LATENCY = 3;
	localparam int PTR_W        = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int MEM_AW       = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int TIMER_W      = $clog2(INIT_CYCLES + REFRESH_PERIOD + REFRESH_CYCLES + 1);

	ctrl_state_e        state;
	logic [TIMER_W-1:0] timer;		// shared by init, refresh interval and refresh length.

	logic              q_write [CMD_DEPTH];
	addr_t             q_addr  [CMD_DEPTH];
	data_t             q_wdata [CMD_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    q_count;
	logic              q_full;
	logic              q_empty;
	logic              exec;		// head entry runs this cycle.

	logic              head_write;
	addr_t             head_addr;
	data_t             head_wdata;
	logic [MEM_AW-1:0] mem_idx;
	data_t             mem [MEM_WORDS];

	logic [READ_LATENCY-1:0] rd_vld_pipe;
	data_t                   rd_dat_pipe [READ_LATENCY];

	assign init_done = (state != INIT);
	assign q_full    = (q_count == (PTR_W+1)'(CMD_DEPTH));
	assign q_empty   = (q_count == '0);
	assign exec      = (state == READY) && !q_empty;

	assign head_write = q_write[rd_ptr];
	assign head_addr  = q_addr[rd_ptr];
	assign head_wdata = q_wdata[rd_ptr];
	assign mem_idx    = MEM_AW'(head_addr % MEM_WORDS);	// window wraps at the array end.

	// init delay, then alternate between command service and refresh.
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state <= INIT;
			timer <= '0;
		end
		else
		begin
			timer <= timer + 1'b1;
			case (state)
				INIT:
				begin
					if (timer == TIMER_W'(INIT_CYCLES - 1))
					begin
						state <= READY;
						timer <= '0;
					end
				end
				READY:
				begin
					if (timer == TIMER_W'(REFRESH_PERIOD - 1))
					begin
						state <= REFRESH;
						timer <= '0;
					end
				end
				default:
				begin
					if (timer == TIMER_W'(REFRESH_CYCLES - 1))
					begin
						state <= READY;
						timer <= '0;
					end
				end
			endcase
		end
	end

	// command queue pointers and occupancy.
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			cmd_credit <= 1'b0;
		end
		else
		begin
			if (cmd_valid)
				wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (exec)
				rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (cmd_valid && !exec)
				q_count <= q_count + 1'b1;
			else if (!cmd_valid && exec)
				q_count <= q_count - 1'b1;
			cmd_credit <= exec;		// one credit back per executed entry.
		end
	end

	always_ff @(posedge Clk)
	begin
		if (cmd_valid)
		begin
			q_write[wr_ptr] <= cmd_write;
			q_addr[wr_ptr]  <= cmd_addr;
			q_wdata[wr_ptr] <= cmd_wdata;
		end
	end

	// array access and read data pipeline.
	always_ff @(posedge Clk)
	begin
		if (exec && head_write)
			mem[mem_idx] <= head_wdata;
		rd_dat_pipe[0] <= mem[mem_idx];
		for (int i = 1; i < READ_LATENCY; i++)
			rd_dat_pipe[i] <= rd_dat_pipe[i-1];
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			rd_vld_pipe <= '0;
		else
			rd_vld_pipe <= {rd_vld_pipe[READ_LATENCY-2:0], exec && !head_write};
	end

	assign rd_valid = rd_vld_pipe[READ_LATENCY-1];
	assign rd_data  = rd_dat_pipe[READ_LATENCY-1];

	// the engine must hold back once its credits are spent.
	a_no_push_full: assert property (@(posedge Clk) disable iff (!rst_n)
		cmd_valid |-> !q_full)
		else $error("command pushed into a full queue");

	// read data returns READ_LATENCY cycles after a read executed in READY.
	a_exec_ready: assert property (@(posedge Clk) disable iff (!rst_n)
		rd_valid |-> $past(state, READ_LATENCY) == READY)
		else $error("command executed outside READY");

endmodule

// File: hw/memtest_pkg.sv
package memtest_pkg;

	// test engine sequence.
	typedef enum logic [2:0] {
		IDLE,		// waiting for start.
		WAIT_INIT,	// holding until the controller finishes init.
		WRITE,		// write pass over the window.
		READ,		// read pass over the window.
		DRAIN		// last reads still in flight.
	} gen_state_e;

	// controller operating mode.
	typedef enum logic [1:0] {
		INIT,		// power-up delay, queue stalled.
		READY,		// executing commands.
		REFRESH		// refresh in progress, queue stalled.
	} ctrl_state_e;

endpackage

// File: hw/mem_cfg_pkg.sv
package mem_cfg_pkg;

	// word address on the command path, wrapped to the array size inside the controller.
	typedef logic [15:0] addr_t;

	// one memory data word.
	typedef logic [15:0] data_t;

	// word and error counts, one bit wider than addr_t so that a full 65536-word window fits.
	typedef logic [16:0] count_t;

endpackage
